// File: logic/axi_chan_slice.sv
module axi_chan_slice #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     resetn,

    input  payload_t in_data,
    input  logic     in_valid,
    output logic     in_ready,

    output payload_t out_data,
    output logic     out_valid,
    input  logic     out_ready
);

    payload_t skid_data;
    logic     skid_valid;
    logic     in_fire;
    logic     main_free;

    assign in_ready  = !skid_valid;  // Registered, breaks the ready path
    assign in_fire   = in_valid && in_ready;
    assign main_free = !out_valid || out_ready;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            out_valid  <= 1'b0;
            skid_valid <= 1'b0;
        end else if (main_free) begin
            out_valid  <= skid_valid || in_fire;
            skid_valid <= 1'b0;
        end else if (in_fire) begin
            skid_valid <= 1'b1;  // Output stalled, park the beat
        end
    end

    always_ff @(posedge clk) begin
        if (main_free)
            out_data <= skid_valid ? skid_data : in_data;
        else if (in_fire)
            skid_data <= in_data;
    end

endmodule

// File: logic/axi_ram_backend.sv
module axi_ram_backend (
    input  logic                  clk,
    input  logic                  resetn,

    input  rammodel_pkg::axi_ar_t ar,
    input  logic                  arvalid,
    output logic                  arready,
    input  rammodel_pkg::axi_aw_t aw,
    input  logic                  awvalid,
    output logic                  awready,
    input  rammodel_pkg::axi_w_t  w,
    input  logic                  wvalid,
    output logic                  wready,
    output rammodel_pkg::axi_r_t  r,
    output logic                  rvalid,
    input  logic                  rready,
    output rammodel_pkg::axi_b_t  b,
    output logic                  bvalid,
    input  logic                  bready
);

    import rammodel_pkg::*;

    typedef enum logic [1:0] {IDLE, RD_DATA, WR_DATA, WR_RESP} ram_state_t;

    ram_state_t state;

    logic [DATA_WIDTH-1:0] mem [MEM_WORDS];

    logic [WORD_AW-1:0]  ptr;
    logic [7:0]          len;
    logic [7:0]          beat;
    logic [ID_WIDTH-1:0] id;

    logic ar_fire, aw_fire, w_fire, r_fire, b_fire;

    assign ar_fire = arvalid && arready;
    assign aw_fire = awvalid && awready;
    assign w_fire  = wvalid && wready;
    assign r_fire  = rvalid && rready;
    assign b_fire  = bvalid && bready;

    assign arready = state == IDLE;
    assign awready = state == IDLE && !arvalid;
    assign wready  = state == WR_DATA;
    assign rvalid  = state == RD_DATA;
    assign bvalid  = state == WR_RESP;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:
                    if (ar_fire)
                        state <= RD_DATA;
                    else if (aw_fire)
                        state <= WR_DATA;
                RD_DATA:
                    if (r_fire && r.last)
                        state <= IDLE;
                WR_DATA:
                    if (w_fire && w.last)
                        state <= WR_RESP;
                WR_RESP:
                    if (b_fire)
                        state <= IDLE;
                default:
                    state <= IDLE;
            endcase
        end
    end

    // Burst context, loaded on every address handshake
    always_ff @(posedge clk) begin
        if (ar_fire) begin
            ptr  <= ar.addr[WORD_LSB +: WORD_AW];
            len  <= ar.len;
            beat <= '0;
            id   <= ar.id;
        end else if (aw_fire) begin
            ptr  <= aw.addr[WORD_LSB +: WORD_AW];
            id   <= aw.id;
        end else if (r_fire || w_fire) begin
            ptr  <= ptr + 1'b1;  // INCR, wraps modulo the array
            beat <= beat + 8'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (w_fire) begin
            for (int i = 0; i < STRB_WIDTH; i++) begin
                if (w.strb[i])
                    mem[ptr][i*8 +: 8] <= w.data[i*8 +: 8];
            end
        end
    end

    assign r = '{id: id, data: mem[ptr], resp: RESP_OKAY, last: beat == len};
    assign b = '{id: id, resp: RESP_OKAY};

endmodule

// File: logic/axi_txn_gate.sv
module axi_txn_gate (
    input  logic                  clk,
    input  logic                  resetn,

    input  rammodel_pkg::axi_ar_t s_ar,
    input  logic                  s_arvalid,
    output logic                  s_arready,
    input  rammodel_pkg::axi_aw_t s_aw,
    input  logic                  s_awvalid,
    output logic                  s_awready,
    input  rammodel_pkg::axi_w_t  s_w,
    input  logic                  s_wvalid,
    output logic                  s_wready,
    output rammodel_pkg::axi_r_t  s_r,
    output logic                  s_rvalid,
    input  logic                  s_rready,
    output rammodel_pkg::axi_b_t  s_b,
    output logic                  s_bvalid,
    input  logic                  s_bready,

    output rammodel_pkg::axi_ar_t m_ar,
    output logic                  m_arvalid,
    input  logic                  m_arready,
    output rammodel_pkg::axi_aw_t m_aw,
    output logic                  m_awvalid,
    input  logic                  m_awready,
    output rammodel_pkg::axi_w_t  m_w,
    output logic                  m_wvalid,
    input  logic                  m_wready,
    input  rammodel_pkg::axi_r_t  m_r,
    input  logic                  m_rvalid,
    output logic                  m_rready,
    input  rammodel_pkg::axi_b_t  m_b,
    input  logic                  m_bvalid,
    output logic                  m_bready,

    input  logic                  pause,
    output logic                  pause_ok,
    input  logic                  resume,
    output logic                  resume_ok
);

    import rammodel_pkg::*;

    typedef enum logic [0:0] {DO_AR, DO_R} rd_state_t;
    typedef enum logic [1:0] {DO_AW, DO_W, DO_B} wr_state_t;
    typedef enum logic [2:0] {NORMAL, ABORT, HOLD, RESUME, READY} ctrl_state_t;

    rd_state_t   rd_state, rd_state_next;
    wr_state_t   wr_state, wr_state_next;
    ctrl_state_t ctrl_state, ctrl_state_next;

    logic s_arfire, s_awfire, s_rfire, s_bfire;
    logic m_arfire, m_awfire, m_wfire, m_rfire, m_bfire;
    logic txn_allowed, abort_resume, pause_trig, idle;

    // Upstream transaction accepted but not yet completed upstream
    logic    rd_live, wr_live;
    axi_ar_t ar_saved;
    axi_aw_t aw_saved;

    logic [7:0] beat_cnt;

    // Handshake position, AR/AW = 0, data beats 1..N, B = N+1
    logic [8:0] r_pos, r_pos_next, r_pos_save;
    logic [8:0] w_pos, w_pos_next, w_pos_save;

    assign s_arfire = s_arvalid && s_arready;
    assign s_awfire = s_awvalid && s_awready;
    assign s_rfire  = s_rvalid && s_rready;
    assign s_bfire  = s_bvalid && s_bready;
    assign m_arfire = m_arvalid && m_arready;
    assign m_awfire = m_awvalid && m_awready;
    assign m_wfire  = m_wvalid && m_wready;
    assign m_rfire  = m_rvalid && m_rready;
    assign m_bfire  = m_bvalid && m_bready;

    assign txn_allowed  = ctrl_state == NORMAL && !pause;
    assign abort_resume = ctrl_state == ABORT || ctrl_state == RESUME;
    assign pause_trig   = ctrl_state == NORMAL && pause;
    assign idle         = rd_state == DO_AR && wr_state == DO_AW;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            rd_live <= 1'b0;
            wr_live <= 1'b0;
        end else if (txn_allowed) begin
            if (s_arfire)
                rd_live <= 1'b1;
            else if (s_rfire && s_r.last)
                rd_live <= 1'b0;
            if (s_awfire)
                wr_live <= 1'b1;
            else if (s_bfire)
                wr_live <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (txn_allowed && s_arfire)
            ar_saved <= s_ar;
        if (txn_allowed && s_awfire)
            aw_saved <= s_aw;
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            rd_state   <= DO_AR;
            wr_state   <= DO_AW;
            ctrl_state <= NORMAL;
            r_pos      <= '0;
            w_pos      <= '0;
        end else begin
            rd_state   <= rd_state_next;
            wr_state   <= wr_state_next;
            ctrl_state <= ctrl_state_next;
            r_pos      <= r_pos_next;
            w_pos      <= w_pos_next;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            r_pos_save <= '0;
            w_pos_save <= '0;
        end else if (pause_trig) begin
            r_pos_save <= r_pos;  // Replay target
            w_pos_save <= w_pos;
        end
    end

    // W beat counter, source of the regenerated wlast
    always_ff @(posedge clk) begin
        if (!resetn)
            beat_cnt <= '0;
        else if (m_wfire)
            beat_cnt <= m_w.last ? 8'd0 : beat_cnt + 8'd1;
    end

    always_comb begin
        if (m_rfire && m_r.last)
            r_pos_next = '0;
        else if (m_arfire || m_rfire)
            r_pos_next = r_pos + 9'd1;
        else
            r_pos_next = r_pos;

        if (m_bfire)
            w_pos_next = '0;
        else if (m_awfire || m_wfire)
            w_pos_next = w_pos + 9'd1;
        else
            w_pos_next = w_pos;
    end

    always_comb begin
        rd_state_next = rd_state;
        case (rd_state)
            DO_AR: if (m_arfire) rd_state_next = DO_R;
            DO_R:  if (m_rfire && m_r.last) rd_state_next = DO_AR;
            default: rd_state_next = DO_AR;
        endcase

        wr_state_next = wr_state;
        case (wr_state)
            DO_AW: if (m_awfire) wr_state_next = DO_W;
            DO_W:  if (m_wfire && m_w.last) wr_state_next = DO_B;
            DO_B:  if (m_bfire) wr_state_next = DO_AW;
            default: wr_state_next = DO_AW;
        endcase
    end

    always_comb begin
        ctrl_state_next = ctrl_state;
        case (ctrl_state)
            NORMAL:
                if (pause)
                    ctrl_state_next = idle ? HOLD : ABORT;
            ABORT:  // Drain the burst in flight toward memory
                if (m_rfire && m_r.last || m_bfire)
                    ctrl_state_next = HOLD;
            HOLD:
                if (resume)
                    ctrl_state_next = rd_live || wr_live ? RESUME : READY;
            RESUME:  // Stop once the replay reaches the cut point
                if (rd_live && r_pos_next == r_pos_save || wr_live && w_pos_next == w_pos_save)
                    ctrl_state_next = READY;
            READY:
                if (!resume)
                    ctrl_state_next = NORMAL;
            default:
                ctrl_state_next = NORMAL;
        endcase
    end

    assign s_arready = idle && txn_allowed && m_arready;
    assign s_awready = idle && txn_allowed && !s_arvalid && m_awready;  // Reads first
    assign s_wready  = wr_state == DO_W && txn_allowed && m_wready;
    assign s_r       = m_r;
    assign s_rvalid  = m_rvalid;
    assign s_b       = m_b;
    assign s_bvalid  = m_bvalid;

    assign m_arvalid = idle && (s_arvalid && txn_allowed || rd_live && abort_resume);
    assign m_ar      = rd_live ? ar_saved : s_ar;
    assign m_rready  = rd_state == DO_R && (s_rready && txn_allowed || abort_resume);
    assign m_awvalid = idle && (!s_arvalid && s_awvalid && txn_allowed || wr_live && abort_resume);
    assign m_aw      = wr_live ? aw_saved : s_aw;
    assign m_wvalid  = wr_state == DO_W && (s_wvalid && txn_allowed || abort_resume);
    assign m_w       = '{data: s_w.data,
                         strb: ctrl_state == NORMAL ? s_w.strb : '0,
                         last: beat_cnt == aw_saved.len};
    assign m_bready  = wr_state == DO_B && (s_bready && txn_allowed || abort_resume);

    assign pause_ok  = ctrl_state == HOLD;
    assign resume_ok = ctrl_state == READY;

endmodule

// File: logic/rammodel_pkg.sv
package rammodel_pkg;

    localparam int ADDR_WIDTH = 32;
    localparam int DATA_WIDTH = 64;
    localparam int ID_WIDTH   = 4;
    localparam int STRB_WIDTH = DATA_WIDTH / 8;
    localparam int MEM_WORDS  = 256;

    // Word index into the backend array
    localparam int WORD_LSB   = $clog2(STRB_WIDTH);
    localparam int WORD_AW    = $clog2(MEM_WORDS);

    localparam logic [1:0] RESP_OKAY = 2'b00;

    typedef struct packed {
        logic [ID_WIDTH-1:0]   id;
        logic [ADDR_WIDTH-1:0] addr;
        logic [7:0]            len;
        logic [2:0]            size;
        logic [1:0]            burst;
    } axi_ar_t;

    typedef struct packed {
        logic [ID_WIDTH-1:0]   id;
        logic [ADDR_WIDTH-1:0] addr;
        logic [7:0]            len;
        logic [2:0]            size;
        logic [1:0]            burst;
    } axi_aw_t;

    typedef struct packed {
        logic [DATA_WIDTH-1:0] data;
        logic [STRB_WIDTH-1:0] strb;
        logic                  last;
    } axi_w_t;

    typedef struct packed {
        logic [ID_WIDTH-1:0]   id;
        logic [DATA_WIDTH-1:0] data;
        logic [1:0]            resp;
        logic                  last;
    } axi_r_t;

    typedef struct packed {
        logic [ID_WIDTH-1:0] id;
        logic [1:0]          resp;
    } axi_b_t;

endpackage

// File: logic/rammodel_top.sv
module rammodel_top (
    input  logic                  clk,
    input  logic                  resetn,

    input  rammodel_pkg::axi_ar_t s_ar,
    input  logic                  s_arvalid,
    output logic                  s_arready,
    input  rammodel_pkg::axi_aw_t s_aw,
    input  logic                  s_awvalid,
    output logic                  s_awready,
    input  rammodel_pkg::axi_w_t  s_w,
    input  logic                  s_wvalid,
    output logic                  s_wready,
    output rammodel_pkg::axi_r_t  s_r,
    output logic                  s_rvalid,
    input  logic                  s_rready,
    output rammodel_pkg::axi_b_t  s_b,
    output logic                  s_bvalid,
    input  logic                  s_bready,

    input  logic                  pause,
    output logic                  pause_ok,
    input  logic                  resume,
    output logic                  resume_ok
);

    import rammodel_pkg::*;

    // Gate side (m_) and backend side of each slice
    axi_ar_t m_ar, ar;
    axi_aw_t m_aw, aw;
    axi_w_t  m_w, w;
    axi_r_t  m_r, r;
    axi_b_t  m_b, b;

    logic m_arvalid, m_arready, arvalid, arready;
    logic m_awvalid, m_awready, awvalid, awready;
    logic m_wvalid, m_wready, wvalid, wready;
    logic m_rvalid, m_rready, rvalid, rready;
    logic m_bvalid, m_bready, bvalid, bready;

    axi_txn_gate u_gate (.*);

    axi_chan_slice #(.payload_t(axi_ar_t)) u_ar_slice (
        .clk, .resetn,
        .in_data(m_ar), .in_valid(m_arvalid), .in_ready(m_arready),
        .out_data(ar), .out_valid(arvalid), .out_ready(arready)
    );

    axi_chan_slice #(.payload_t(axi_aw_t)) u_aw_slice (
        .clk, .resetn,
        .in_data(m_aw), .in_valid(m_awvalid), .in_ready(m_awready),
        .out_data(aw), .out_valid(awvalid), .out_ready(awready)
    );

    axi_chan_slice #(.payload_t(axi_w_t)) u_w_slice (
        .clk, .resetn,
        .in_data(m_w), .in_valid(m_wvalid), .in_ready(m_wready),
        .out_data(w), .out_valid(wvalid), .out_ready(wready)
    );

    // Response channels run back toward the gate
    axi_chan_slice #(.payload_t(axi_r_t)) u_r_slice (
        .clk, .resetn,
        .in_data(r), .in_valid(rvalid), .in_ready(rready),
        .out_data(m_r), .out_valid(m_rvalid), .out_ready(m_rready)
    );

    axi_chan_slice #(.payload_t(axi_b_t)) u_b_slice (
        .clk, .resetn,
        .in_data(b), .in_valid(bvalid), .in_ready(bready),
        .out_data(m_b), .out_valid(m_bvalid), .out_ready(m_bready)
    );

    axi_ram_backend u_ram (.*);

endmodule

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module rammodel_tb -f sim.f -o rammodel_sim

out=$(./obj_dir/rammodel_sim 2>&1) || true
echo "$out"

if echo "$out" | grep -q "Test completed successfully"; then
    exit 0
fi
exit 1

// File: sim.f
+incdir+test
logic/rammodel_pkg.sv
logic/axi_chan_slice.sv
logic/axi_txn_gate.sv
logic/axi_ram_backend.sv
logic/rammodel_top.sv
test/rammodel_tb.sv

// File: test/rammodel_tests.svh
`ifndef RAMMODEL_TESTS_SVH
`define RAMMODEL_TESTS_SVH

// Every helper starts and ends on a falling edge and samples 1 unit after it

function automatic logic [DATA_WIDTH-1:0] fill_word(int word);
    logic [7:0] w;
    w = 8'(word);
    return {4{w ^ 8'ha5, w}};
endfunction

task automatic random_beats(int len);
    for (int i = 0; i <= len; i++) begin
        wr_data[i] = {$urandom, $urandom};
        wr_strb[i] = 8'($urandom);
    end
endtask

task automatic commit_beats(int word, int len);
    for (int i = 0; i <= len; i++)
        model_write(word + i, wr_data[i], wr_strb[i]);
endtask

task automatic present_ar(int word, int len, logic [3:0] id);
    s_ar = '{id: id, addr: ADDR_WIDTH'(word * STRB_WIDTH), len: 8'(len), size: 3'd3,
             burst: 2'b01};
    s_arvalid = 1'b1;
endtask

task automatic send_ar(int word, int len, logic [3:0] id);
    present_ar(word, len, id);
    #1;
    while (!s_arready) begin
        @(negedge clk);
        #1;
    end
    @(negedge clk);
    s_arvalid = 1'b0;
endtask

task automatic send_aw(int word, int len, logic [3:0] id);
    s_aw = '{id: id, addr: ADDR_WIDTH'(word * STRB_WIDTH), len: 8'(len), size: 3'd3,
             burst: 2'b01};
    s_awvalid = 1'b1;
    #1;
    while (!s_awready) begin
        @(negedge clk);
        #1;
    end
    @(negedge clk);
    s_awvalid = 1'b0;
endtask

task automatic send_w(int first, int stop, int len, bit gaps);
    int beat;
    beat = first;
    while (beat < stop) begin
        s_wvalid = gaps ? ($urandom % 3 != 0) : 1'b1;
        s_w = '{data: wr_data[beat], strb: wr_strb[beat], last: beat == len};
        #1;
        if (s_wvalid && s_wready)
            beat++;
        @(negedge clk);
    end
    s_wvalid = 1'b0;
endtask

task automatic take_b(string test, logic [3:0] id, bit gaps);
    bit seen;
    seen = 1'b0;
    while (!seen) begin
        s_bready = gaps ? ($urandom % 2 == 0) : 1'b1;
        #1;
        if (s_bvalid && s_bready) begin
            check_equal({test, " bid"}, 64'(id), 64'(s_b.id));
            check_equal({test, " bresp"}, 64'd0, 64'(s_b.resp));  // OKAY only
            seen = 1'b1;
        end
        @(negedge clk);
    end
    s_bready = 1'b0;
endtask

task automatic take_r(string test, int word, int len, logic [3:0] id, int first, int stop,
                      bit gaps);
    int beat;
    beat = first;
    while (beat < stop) begin
        s_rready = gaps ? ($urandom % 2 == 0) : 1'b1;
        #1;
        if (s_rvalid && s_rready) begin
            check_equal({test, " rdata"}, model_word(word + beat), s_r.data);
            check_equal({test, " rid"}, 64'(id), 64'(s_r.id));
            check_equal({test, " rresp"}, 64'd0, 64'(s_r.resp));
            check_equal({test, " rlast"}, 64'(beat == len), 64'(s_r.last));
            beat++;
        end
        @(negedge clk);
    end
    s_rready = 1'b0;
endtask

// Nothing left over once a burst has completed
task automatic check_idle(string test);
    repeat (3) begin
        #1;
        check_equal({test, " rvalid after burst"}, 64'd0, 64'(s_rvalid));
        check_equal({test, " bvalid after burst"}, 64'd0, 64'(s_bvalid));
        @(negedge clk);
    end
endtask

task automatic write_burst(string test, int word, int len, logic [3:0] id, bit gaps);
    send_aw(word, len, id);
    send_w(0, len + 1, len, gaps);
    take_b(test, id, gaps);
    commit_beats(word, len);
    check_idle(test);
endtask

task automatic read_burst(string test, int word, int len, logic [3:0] id, bit gaps);
    send_ar(word, len, id);
    take_r(test, word, len, id, 0, len + 1, gaps);
    check_idle(test);
endtask

// Upstream stays frozen from pause until the gate is back in NORMAL
task automatic pause_and_resume(string test);
    pause = 1'b1;
    do begin
        #1;
        check_equal({test, " arready paused"}, 64'd0, 64'(s_arready));
        check_equal({test, " awready paused"}, 64'd0, 64'(s_awready));
        @(negedge clk);
    end while (!pause_ok);
    resume = 1'b1;
    do begin
        #1;
        check_equal({test, " arready resuming"}, 64'd0, 64'(s_arready));
        check_equal({test, " awready resuming"}, 64'd0, 64'(s_awready));
        @(negedge clk);
    end while (!resume_ok);
    pause  = 1'b0;
    resume = 1'b0;
    @(negedge clk);  // READY back to NORMAL
    check_equal({test, " resume_ok released"}, 64'd0, 64'(resume_ok));
endtask

task automatic preload_memory();
    for (int i = 0; i < MEM_WORDS; i++) begin
        wr_data[i] = fill_word(i);
        wr_strb[i] = '1;
    end
    write_burst("preload", 0, MEM_WORDS - 1, 4'h0, 1'b0);
endtask

task automatic write_then_read();
    random_beats(7);
    write_burst("write_then_read", 16, 7, 4'h3, 1'b0);
    read_burst("write_then_read", 16, 7, 4'h5, 1'b0);
endtask

task automatic backpressure_bursts();
    int word;
    int len;
    for (int n = 0; n < 4; n++) begin
        word = $urandom % MEM_WORDS;  // May wrap past the top of the array
        len  = $urandom % 16;
        random_beats(len);
        write_burst("backpressure", word, len, 4'(n), 1'b1);
        read_burst("backpressure", word, len, 4'(n + 8), 1'b1);
    end
endtask

task automatic pause_when_idle();
    present_ar(16, 7, 4'h6);  // Held through the whole pause
    pause_and_resume("pause_when_idle");
    read_burst("pause_when_idle", 16, 7, 4'h6, 1'b0);
endtask

task automatic pause_mid_read();
    random_beats(15);
    write_burst("pause_mid_read", 32, 15, 4'h2, 1'b0);
    send_ar(32, 15, 4'h9);
    take_r("pause_mid_read", 32, 15, 4'h9, 0, 3, 1'b0);
    pause_and_resume("pause_mid_read");
    take_r("pause_mid_read", 32, 15, 4'h9, 3, 16, 1'b0);
    check_idle("pause_mid_read");
endtask

task automatic pause_mid_write();
    random_beats(11);
    send_aw(64, 11, 4'hc);
    send_w(0, 4, 11, 1'b0);
    pause_and_resume("pause_mid_write");
    send_w(4, 12, 11, 1'b0);
    take_b("pause_mid_write", 4'hc, 1'b0);
    commit_beats(64, 11);
    check_idle("pause_mid_write");
    // Aborted and replayed beats carry zero strobes
    read_burst("pause_mid_write", 64, 11, 4'hd, 1'b0);
endtask

`endif

// File: test/rammodel_tb.sv
module rammodel_tb;

    import rammodel_pkg::*;

    // About a thousand cycles of traffic in all, with a wide margin
    localparam int TIMEOUT_CYCLES = 20000;

    logic    clk = 1'b0;
    logic    resetn;
    axi_ar_t s_ar;
    logic    s_arvalid, s_arready;
    axi_aw_t s_aw;
    logic    s_awvalid, s_awready;
    axi_w_t  s_w;
    logic    s_wvalid, s_wready;
    axi_r_t  s_r;
    logic    s_rvalid, s_rready;
    axi_b_t  s_b;
    logic    s_bvalid, s_bready;
    logic    pause, pause_ok, resume, resume_ok;

    int unsigned cycle_count = 0;

    logic [7:0] ref_mem [MEM_WORDS*STRB_WIDTH];  // Byte-wide reference memory

    // Beats of the burst being written
    logic [DATA_WIDTH-1:0] wr_data [MEM_WORDS];
    logic [STRB_WIDTH-1:0] wr_strb [MEM_WORDS];

    rammodel_top UUT (.*);

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Test failed");
            $fatal(1);
        end
    end

    task automatic fail_run(string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_equal(string test, logic [63:0] exp, logic [63:0] act);
        assert (act === exp)
        else fail_run($sformatf("FAIL %s: expected %h, actual %h", test, exp, act));
    endtask

    function automatic void model_write(int word, logic [DATA_WIDTH-1:0] data,
                                        logic [STRB_WIDTH-1:0] strb);
        for (int i = 0; i < STRB_WIDTH; i++) begin
            if (strb[i])
                ref_mem[(word % MEM_WORDS) * STRB_WIDTH + i] = data[i*8 +: 8];
        end
    endfunction

    function automatic logic [DATA_WIDTH-1:0] model_word(int word);
        logic [DATA_WIDTH-1:0] value;
        for (int i = 0; i < STRB_WIDTH; i++)
            value[i*8 +: 8] = ref_mem[(word % MEM_WORDS) * STRB_WIDTH + i];
        return value;
    endfunction

    `include "rammodel_tests.svh"

    initial begin
        void'($urandom(32'h8eec));
        resetn    = 1'b0;
        s_ar      = '0;
        s_arvalid = 1'b0;
        s_aw      = '0;
        s_awvalid = 1'b0;
        s_w       = '0;
        s_wvalid  = 1'b0;
        s_rready  = 1'b0;
        s_bready  = 1'b0;
        pause     = 1'b0;
        resume    = 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;

        preload_memory();
        write_then_read();
        backpressure_bursts();
        pause_when_idle();
        pause_mid_read();
        pause_mid_write();

        $display("Test completed successfully");
        $finish;
    end

endmodule
